// ==== verilog/video_pkg.sv ====
`default_nettype none

package video_pkg;

    // Coordinates cover rasters up to 4095 x 4095
    typedef logic [11:0] pix_x_t;
    typedef logic [11:0] pix_y_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    // ------------------------------
    // Video beat
    // ------------------------------

    // Everything that travels with one pixel clock of video
    typedef struct packed {
        logic   hsync;
        logic   vsync;
        logic   de;
        pix_x_t x;
        pix_y_t y;
        rgb_t   pix;
    } video_beat_t;

    // Both sync signals are active high
    localparam logic SYNC_ACTIVE = 1'b1;

    // Constant blue level of the test pattern
    localparam logic [7:0] PATTERN_BLUE = 8'h40;

endpackage : video_pkg

`default_nettype wire

// ==== verilog/apb_pkg.sv ====
`default_nettype none

package apb_pkg;

    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        logic      pready;
        logic      pslverr;
        apb_data_t prdata;
    } apb_rsp_t;

    // ------------------------------
    // Register map
    // ------------------------------

    // Offsets inside one box record that repeats every BOX_STRIDE bytes
    localparam apb_addr_t   REG_START  = 8'h00;
    localparam apb_addr_t   REG_END    = 8'h04;
    localparam apb_addr_t   REG_COLOR  = 8'h08;
    localparam apb_addr_t   REG_RSVD   = 8'h0C;
    localparam int unsigned BOX_STRIDE = 16;

    // Field positions of a corner register
    localparam int unsigned X_LSB = 0;
    localparam int unsigned Y_LSB = 16;

    typedef struct packed {
        video_pkg::pix_x_t start_x;
        video_pkg::pix_y_t start_y;
        video_pkg::pix_x_t end_x;
        video_pkg::pix_y_t end_y;
        video_pkg::rgb_t   color;
    } box_t;

endpackage : apb_pkg

`default_nettype wire

// ==== verilog/video_timing_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module video_timing_gen #(
    parameter int H_ACT   = 1280,
    parameter int H_TOTAL = 1650,
    parameter int V_ACT   = 720,
    parameter int V_TOTAL = 750
) (
    input  wire                    pix_clk,
    input  wire                    i_rst,
    output video_pkg::video_beat_t o_beat
);

    localparam video_pkg::pix_x_t H_LAST    = video_pkg::pix_x_t'(H_TOTAL - 1);
    localparam video_pkg::pix_y_t V_LAST    = video_pkg::pix_y_t'(V_TOTAL - 1);
    localparam video_pkg::pix_x_t H_ACT_END = video_pkg::pix_x_t'(H_ACT);
    localparam video_pkg::pix_y_t V_ACT_END = video_pkg::pix_y_t'(V_ACT);

    // Sync windows sit a little after the end of the active area
    localparam video_pkg::pix_x_t HS_FIRST = video_pkg::pix_x_t'(H_ACT + 2);
    localparam video_pkg::pix_x_t HS_LAST  = video_pkg::pix_x_t'(H_ACT + 5);
    localparam video_pkg::pix_y_t VS_FIRST = video_pkg::pix_y_t'(V_ACT + 1);
    localparam video_pkg::pix_y_t VS_LAST  = video_pkg::pix_y_t'(V_ACT + 2);

    video_pkg::pix_x_t h_cnt;
    video_pkg::pix_y_t v_cnt;
    logic              hsync_c;
    logic              vsync_c;
    logic              de_c;

    // ------------------------------
    // Raster counters
    // ------------------------------

    always_ff @(posedge pix_clk) begin
        if (i_rst) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == H_LAST) begin
            h_cnt <= '0;
            if (v_cnt == V_LAST) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    assign hsync_c = (h_cnt >= HS_FIRST) && (h_cnt <= HS_LAST);
    assign vsync_c = (v_cnt >= VS_FIRST) && (v_cnt <= VS_LAST);
    assign de_c    = (h_cnt < H_ACT_END) && (v_cnt < V_ACT_END);

    // ------------------------------
    // Output register
    // ------------------------------

    always_ff @(posedge pix_clk) begin
        o_beat.x     <= h_cnt;
        o_beat.y     <= v_cnt;
        // Test pattern is a horizontal red ramp over a vertical green ramp
        o_beat.pix.r <= h_cnt[7:0];
        o_beat.pix.g <= v_cnt[7:0];
        o_beat.pix.b <= video_pkg::PATTERN_BLUE;
        if (i_rst) begin
            o_beat.hsync <= ~video_pkg::SYNC_ACTIVE;
            o_beat.vsync <= ~video_pkg::SYNC_ACTIVE;
            o_beat.de    <= 1'b0;
        end else begin
            o_beat.hsync <= hsync_c ? video_pkg::SYNC_ACTIVE : ~video_pkg::SYNC_ACTIVE;
            o_beat.vsync <= vsync_c ? video_pkg::SYNC_ACTIVE : ~video_pkg::SYNC_ACTIVE;
            o_beat.de    <= de_c;
        end
    end

endmodule : video_timing_gen

`default_nettype wire

// ==== verilog/box_reg_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module box_reg_bank #(
    parameter int N_BOX = 4
) (
    input  wire                    pix_clk,
    input  wire                    i_rst,
    input  wire apb_pkg::apb_req_t i_apb,
    output apb_pkg::apb_rsp_t      o_apb,
    input  wire                    i_vsync,
    output apb_pkg::box_t          o_boxes [N_BOX]
);

    localparam int unsigned ADDR_LIMIT = N_BOX * apb_pkg::BOX_STRIDE;
    localparam int unsigned IDX_SHIFT  = $clog2(apb_pkg::BOX_STRIDE);
    localparam int unsigned COORD_W    = $bits(video_pkg::pix_x_t);

    apb_pkg::box_t      staged [N_BOX];
    apb_pkg::apb_addr_t box_idx;
    apb_pkg::apb_addr_t reg_off;
    logic               access;
    logic               addr_err;
    logic               vsync_d;
    logic               vsync_rise;

    assign access  = i_apb.psel && i_apb.penable;
    assign box_idx = i_apb.paddr >> IDX_SHIFT;
    // Byte lane bits are ignored because registers are word wide
    assign reg_off = i_apb.paddr & apb_pkg::apb_addr_t'(apb_pkg::BOX_STRIDE - 4);

    assign addr_err = (reg_off == apb_pkg::REG_RSVD) || (32'(i_apb.paddr) >= ADDR_LIMIT);

    // ------------------------------
    // Staged registers
    // ------------------------------

    always_ff @(posedge pix_clk) begin
        if (i_rst) begin
            for (int i = 0; i < N_BOX; i++) begin
                staged[i] <= '0;
            end
        end else if (access && i_apb.pwrite && !addr_err) begin
            for (int i = 0; i < N_BOX; i++) begin
                if (box_idx == apb_pkg::apb_addr_t'(i)) begin
                    case (reg_off)
                        apb_pkg::REG_START: begin
                            staged[i].start_x <= i_apb.pwdata[apb_pkg::X_LSB +: COORD_W];
                            staged[i].start_y <= i_apb.pwdata[apb_pkg::Y_LSB +: COORD_W];
                        end
                        apb_pkg::REG_END: begin
                            staged[i].end_x <= i_apb.pwdata[apb_pkg::X_LSB +: COORD_W];
                            staged[i].end_y <= i_apb.pwdata[apb_pkg::Y_LSB +: COORD_W];
                        end
                        apb_pkg::REG_COLOR: begin
                            staged[i].color <= i_apb.pwdata[23:0];
                        end
                        default: ;
                    endcase
                end
            end
        end
    end

    // Reads always return the staged copy, never the active one
    always_comb begin
        apb_pkg::box_t rd_box;
        rd_box = '0;
        for (int i = 0; i < N_BOX; i++) begin
            if (box_idx == apb_pkg::apb_addr_t'(i)) begin
                rd_box = staged[i];
            end
        end
        o_apb.pready  = 1'b1;
        o_apb.pslverr = access && addr_err;
        o_apb.prdata  = '0;
        if (!addr_err) begin
            case (reg_off)
                apb_pkg::REG_START: begin
                    o_apb.prdata[apb_pkg::X_LSB +: COORD_W] = rd_box.start_x;
                    o_apb.prdata[apb_pkg::Y_LSB +: COORD_W] = rd_box.start_y;
                end
                apb_pkg::REG_END: begin
                    o_apb.prdata[apb_pkg::X_LSB +: COORD_W] = rd_box.end_x;
                    o_apb.prdata[apb_pkg::Y_LSB +: COORD_W] = rd_box.end_y;
                end
                apb_pkg::REG_COLOR: begin
                    o_apb.prdata[23:0] = rd_box.color;
                end
                default: ;
            endcase
        end
    end

    // ------------------------------
    // Frame-synchronous copy
    // ------------------------------

    assign vsync_rise = (vsync_d != video_pkg::SYNC_ACTIVE) &&
                        (i_vsync == video_pkg::SYNC_ACTIVE);

    always_ff @(posedge pix_clk) begin
        if (i_rst) begin
            vsync_d <= ~video_pkg::SYNC_ACTIVE;
            for (int i = 0; i < N_BOX; i++) begin
                o_boxes[i] <= '0;
            end
        end else begin
            vsync_d <= i_vsync;
            if (vsync_rise) begin
                for (int i = 0; i < N_BOX; i++) begin
                    o_boxes[i] <= staged[i];
                end
            end
        end
    end

endmodule : box_reg_bank

`default_nettype wire

// ==== verilog/draw_window.sv ====
`timescale 1ns/1ps
`default_nettype none

module draw_window #(
    parameter int N_BOX       = 4,
    parameter int H_BOX_WIDTH = 1,
    parameter int V_BOX_WIDTH = 1
) (
    input  wire                         pix_clk,
    input  wire                         i_rst,
    input  wire video_pkg::video_beat_t i_beat,
    input  wire apb_pkg::box_t          i_boxes [N_BOX],
    output video_pkg::video_beat_t      o_video
);

    // One extra bit so that rectangle edges at the raster border do not wrap
    typedef logic [$bits(video_pkg::pix_x_t):0] edge_t;

    localparam edge_t H_W = edge_t'(H_BOX_WIDTH);
    localparam edge_t V_W = edge_t'(V_BOX_WIDTH);

    logic [N_BOX-1:0] hit;
    video_pkg::rgb_t  pix_out;
    edge_t            beat_x;
    edge_t            beat_y_lift;

    // Moving the beat down by the border width replaces start_y and end_y minus V_W
    assign beat_x      = edge_t'(i_beat.x);
    assign beat_y_lift = edge_t'(i_beat.y) + V_W;

    // ------------------------------
    // Per-box outline test
    // ------------------------------

    for (genvar i = 0; i < N_BOX; i++) begin : g_box
        edge_t outer_x1;
        edge_t inner_x0;
        logic  outer_hit;
        logic  inner_hit;
        logic  box_valid;

        // The outer rectangle reaches past end_x and above start_y
        assign outer_x1 = edge_t'(i_boxes[i].end_x) + H_W;
        assign inner_x0 = edge_t'(i_boxes[i].start_x) + H_W;

        assign outer_hit = (i_beat.x >= i_boxes[i].start_x) && (beat_x <= outer_x1) &&
                           (beat_y_lift >= edge_t'(i_boxes[i].start_y)) &&
                           (i_beat.y <= i_boxes[i].end_y);
        assign inner_hit = (beat_x >= inner_x0) && (i_beat.x <= i_boxes[i].end_x) &&
                           (i_beat.y >= i_boxes[i].start_y) &&
                           (beat_y_lift <= edge_t'(i_boxes[i].end_y));

        // All-zero corners mean the box slot is unused
        assign box_valid = |{i_boxes[i].start_x, i_boxes[i].start_y,
                             i_boxes[i].end_x, i_boxes[i].end_y};

        assign hit[i] = box_valid && outer_hit && !inner_hit;
    end

    // Later boxes overwrite earlier ones, so the highest index wins
    always_comb begin
        pix_out = i_beat.pix;
        for (int i = 0; i < N_BOX; i++) begin
            if (hit[i]) begin
                pix_out = i_boxes[i].color;
            end
        end
    end

    // ------------------------------
    // Output register
    // ------------------------------

    always_ff @(posedge pix_clk) begin
        o_video.x   <= i_beat.x;
        o_video.y   <= i_beat.y;
        o_video.pix <= pix_out;
        if (i_rst) begin
            o_video.hsync <= ~video_pkg::SYNC_ACTIVE;
            o_video.vsync <= ~video_pkg::SYNC_ACTIVE;
            o_video.de    <= 1'b0;
        end else begin
            o_video.hsync <= i_beat.hsync;
            o_video.vsync <= i_beat.vsync;
            o_video.de    <= i_beat.de;
        end
    end

endmodule : draw_window

`default_nettype wire

// ==== verilog/video_overlay_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module video_overlay_top #(
    parameter int H_ACT       = 1280,
    parameter int H_TOTAL     = 1650,
    parameter int V_ACT       = 720,
    parameter int V_TOTAL     = 750,
    parameter int N_BOX       = 4,
    parameter int H_BOX_WIDTH = 1,
    parameter int V_BOX_WIDTH = 1
) (
    input  wire                    pix_clk,
    input  wire                    i_rst,
    input  wire apb_pkg::apb_req_t i_apb,
    output apb_pkg::apb_rsp_t      o_apb,
    output video_pkg::video_beat_t o_video
);

    video_pkg::video_beat_t src_beat;
    apb_pkg::box_t          active_boxes [N_BOX];

    video_timing_gen #(
        .H_ACT   (H_ACT),
        .H_TOTAL (H_TOTAL),
        .V_ACT   (V_ACT),
        .V_TOTAL (V_TOTAL)
    ) timing_i (
        .pix_clk (pix_clk),
        .i_rst   (i_rst),
        .o_beat  (src_beat)
    );

    // Only the vsync bit of the source beat reaches the register bank
    box_reg_bank #(
        .N_BOX (N_BOX)
    ) regs_i (
        .pix_clk (pix_clk),
        .i_rst   (i_rst),
        .i_apb   (i_apb),
        .o_apb   (o_apb),
        .i_vsync (src_beat.vsync),
        .o_boxes (active_boxes)
    );

    draw_window #(
        .N_BOX       (N_BOX),
        .H_BOX_WIDTH (H_BOX_WIDTH),
        .V_BOX_WIDTH (V_BOX_WIDTH)
    ) draw_i (
        .pix_clk (pix_clk),
        .i_rst   (i_rst),
        .i_beat  (src_beat),
        .i_boxes (active_boxes),
        .o_video (o_video)
    );

endmodule : video_overlay_top

`default_nettype wire

// ==== sim/overlay_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module overlay_checker #(
    parameter int H_ACT       = 32,
    parameter int H_TOTAL     = 40,
    parameter int V_ACT       = 16,
    parameter int V_TOTAL     = 20,
    parameter int N_BOX       = 2,
    parameter int H_BOX_WIDTH = 1,
    parameter int V_BOX_WIDTH = 1
) (
    input  wire                         pix_clk,
    input  wire                         i_rst,
    input  wire apb_pkg::apb_req_t      i_apb,
    input  wire apb_pkg::apb_rsp_t      i_rsp,
    input  wire apb_pkg::apb_data_t     i_exp_rdata,
    input  wire                         i_exp_err,
    input  wire video_pkg::video_beat_t i_video,
    output int                          o_errors
);

    // Cycles after reset before the output beats carry a clean raster
    localparam int SETTLE_CYCLES = 4;
    localparam int MAX_ERR_LINES = 30;

    apb_pkg::box_t          staged [N_BOX];
    apb_pkg::box_t          staged_prev [N_BOX];
    apb_pkg::box_t          active [N_BOX];
    video_pkg::video_beat_t beat_prev;
    logic                   vsync_prev;
    int                     settle;
    int                     err_cnt = 0;

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        err_cnt++;
        if (err_cnt <= MAX_ERR_LINES) begin
            $display("ERR %s got 0x%h expected 0x%h at time %0t", name, got, exp, $time);
        end
    endtask

    // The outline is the outer rectangle minus the inner one and unused slots have zero corners
    function automatic logic outline_hit(input apb_pkg::box_t bx, input int x, input int y);
        int   sx;
        int   sy;
        int   ex;
        int   ey;
        logic outer;
        logic inner;
        sx = int'(bx.start_x);
        sy = int'(bx.start_y);
        ex = int'(bx.end_x);
        ey = int'(bx.end_y);
        outer = (x >= sx) && (x <= ex + H_BOX_WIDTH) && (y >= sy - V_BOX_WIDTH) && (y <= ey);
        inner = (x >= sx + H_BOX_WIDTH) && (x <= ex) && (y >= sy) && (y <= ey - V_BOX_WIDTH);
        return (sx != 0 || sy != 0 || ex != 0 || ey != 0) && outer && !inner;
    endfunction

    function automatic video_pkg::rgb_t expected_pixel(input int x, input int y);
        video_pkg::rgb_t pix;
        pix.r = x[7:0];
        pix.g = y[7:0];
        pix.b = 8'h40;
        for (int i = 0; i < N_BOX; i++) begin
            if (outline_hit(active[i], x, y)) begin
                pix = active[i].color;
            end
        end
        return pix;
    endfunction

    // ------------------------------
    // Per-cycle model and compare
    // ------------------------------

    always @(posedge pix_clk) begin : observe
        int                 x;
        int                 y;
        int                 nx;
        int                 ny;
        int                 idx;
        logic               access;
        logic               addr_err;
        logic               exp_hs;
        logic               exp_vs;
        logic               exp_de;
        apb_pkg::apb_addr_t off;
        video_pkg::rgb_t    exp_pix;
        x        = int'(i_video.x);
        y        = int'(i_video.y);
        access   = i_apb.psel && i_apb.penable;
        idx      = int'(i_apb.paddr) / 16;
        off      = i_apb.paddr & 8'h0C;
        addr_err = (off == apb_pkg::REG_RSVD) || (int'(i_apb.paddr) >= N_BOX * 16);
        if (i_rst) begin
            for (int i = 0; i < N_BOX; i++) begin
                staged[i]      = '0;
                staged_prev[i] = '0;
                active[i]      = '0;
            end
            vsync_prev = 1'b0;
            settle     = 0;
        end else begin
            if (access) begin
                if (i_rsp.pslverr !== i_exp_err) begin
                    report_mismatch("o_apb.pslverr", 32'(i_rsp.pslverr), 32'(i_exp_err));
                end
                if (!i_apb.pwrite && i_rsp.prdata !== i_exp_rdata) begin
                    report_mismatch("o_apb.prdata", i_rsp.prdata, i_exp_rdata);
                end
            end
            if (settle < SETTLE_CYCLES) begin
                settle++;
            end else begin
                nx = (int'(beat_prev.x) == H_TOTAL - 1) ? 0 : int'(beat_prev.x) + 1;
                ny = int'(beat_prev.y);
                if (int'(beat_prev.x) == H_TOTAL - 1) begin
                    ny = (ny == V_TOTAL - 1) ? 0 : ny + 1;
                end
                exp_hs = (x >= H_ACT + 2) && (x <= H_ACT + 5);
                exp_vs = (y >= V_ACT + 1) && (y <= V_ACT + 2);
                exp_de = (x < H_ACT) && (y < V_ACT);
                if (x != nx) report_mismatch("o_video.x", x, nx);
                if (y != ny) report_mismatch("o_video.y", y, ny);
                if (i_video.hsync !== exp_hs) begin
                    report_mismatch("o_video.hsync", 32'(i_video.hsync), 32'(exp_hs));
                end
                if (i_video.vsync !== exp_vs) begin
                    report_mismatch("o_video.vsync", 32'(i_video.vsync), 32'(exp_vs));
                end
                if (i_video.de !== exp_de) begin
                    report_mismatch("o_video.de", 32'(i_video.de), 32'(exp_de));
                end
                exp_pix = expected_pixel(x, y);
                if (i_video.de && i_video.pix !== exp_pix) begin
                    report_mismatch("o_video.pix", 32'(i_video.pix), 32'(exp_pix));
                end
            end
            // The copy at vsync takes the staged set from before the previous cycle's write
            if (!vsync_prev && i_video.vsync) begin
                active = staged_prev;
            end
            vsync_prev  = i_video.vsync;
            staged_prev = staged;
            if (access && i_apb.pwrite && !addr_err) begin
                case (off)
                    apb_pkg::REG_START: begin
                        staged[idx].start_x = i_apb.pwdata[11:0];
                        staged[idx].start_y = i_apb.pwdata[27:16];
                    end
                    apb_pkg::REG_END: begin
                        staged[idx].end_x = i_apb.pwdata[11:0];
                        staged[idx].end_y = i_apb.pwdata[27:16];
                    end
                    apb_pkg::REG_COLOR: staged[idx].color = i_apb.pwdata[23:0];
                    default: ;
                endcase
            end
        end
        beat_prev = i_video;
        o_errors <= err_cnt;
    end

endmodule : overlay_checker

`default_nettype wire

// ==== sim/tb_video_overlay.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_video_overlay;

    localparam int H_ACT         = 32;
    localparam int H_TOTAL       = 40;
    localparam int V_ACT         = 16;
    localparam int V_TOTAL       = 20;
    localparam int N_BOX         = 2;
    localparam int H_BOX_WIDTH   = 1;
    localparam int V_BOX_WIDTH   = 1;
    localparam int N_FIELDS      = 5;
    localparam int MAX_OPS       = 64;
    localparam int FRAME_TIMEOUT = 2 * H_TOTAL * V_TOTAL;
    localparam int READY_TIMEOUT = 16;

    // Operation codes in the first column of the vector file
    localparam logic [31:0] OP_WRITE    = 32'h0;
    localparam logic [31:0] OP_READ     = 32'h1;
    localparam logic [31:0] OP_FRAME    = 32'h2;
    localparam logic [31:0] OP_IDLE     = 32'h3;
    localparam logic [31:0] OP_END_TEST = 32'h4;

    logic                   pix_clk;
    logic                   rst;
    apb_pkg::apb_req_t      apb_req;
    apb_pkg::apb_rsp_t      apb_rsp;
    video_pkg::video_beat_t video;
    apb_pkg::apb_data_t     exp_rdata;
    logic                   exp_err;
    int                     checker_errors;
    logic [31:0]            vectors [0:N_FIELDS*MAX_OPS-1];
    string                  test_names [5];

    video_overlay_top #(
        .H_ACT       (H_ACT),
        .H_TOTAL     (H_TOTAL),
        .V_ACT       (V_ACT),
        .V_TOTAL     (V_TOTAL),
        .N_BOX       (N_BOX),
        .H_BOX_WIDTH (H_BOX_WIDTH),
        .V_BOX_WIDTH (V_BOX_WIDTH)
    ) dut_i (
        .pix_clk (pix_clk),
        .i_rst   (rst),
        .i_apb   (apb_req),
        .o_apb   (apb_rsp),
        .o_video (video)
    );

    overlay_checker #(
        .H_ACT       (H_ACT),
        .H_TOTAL     (H_TOTAL),
        .V_ACT       (V_ACT),
        .V_TOTAL     (V_TOTAL),
        .N_BOX       (N_BOX),
        .H_BOX_WIDTH (H_BOX_WIDTH),
        .V_BOX_WIDTH (V_BOX_WIDTH)
    ) checker_i (
        .pix_clk     (pix_clk),
        .i_rst       (rst),
        .i_apb       (apb_req),
        .i_rsp       (apb_rsp),
        .i_exp_rdata (exp_rdata),
        .i_exp_err   (exp_err),
        .i_video     (video),
        .o_errors    (checker_errors)
    );

    initial begin
        pix_clk = 1'b0;
        forever #10 pix_clk = ~pix_clk;
    end

    // ------------------------------
    // APB and frame tasks
    // ------------------------------

    task automatic apb_access(input logic write, input apb_pkg::apb_addr_t addr,
                              input apb_pkg::apb_data_t wdata, input apb_pkg::apb_data_t rdata,
                              input logic err, output bit ok);
        int n;
        @(posedge pix_clk);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= write;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= wdata;
        exp_rdata       <= rdata;
        exp_err         <= err;
        @(posedge pix_clk);
        apb_req.penable <= 1'b1;
        ok = 1'b0;
        n  = 0;
        while (!ok && n < READY_TIMEOUT) begin
            @(posedge pix_clk);
            ok = apb_rsp.pready;
            n++;
        end
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
    endtask

    task automatic wait_frame(output bit ok);
        int   n;
        logic vs_last;
        ok      = 1'b0;
        n       = 0;
        vs_last = video.vsync;
        while (!ok && n < FRAME_TIMEOUT) begin
            @(posedge pix_clk);
            if (!vs_last && video.vsync) ok = 1'b1;
            vs_last = video.vsync;
            n++;
        end
    endtask

    // ------------------------------
    // Vector sequencing
    // ------------------------------

    initial begin : run_tests
        int          base;
        int          op_i;
        int          fails;
        int          tests_run;
        int          tests_failed;
        int          errors_before;
        bit          ok;
        bit          done;
        bit          hung;
        logic [31:0] op;
        rst           = 1'b1;
        apb_req       = '0;
        exp_rdata     = '0;
        exp_err       = 1'b0;
        tests_run     = 0;
        tests_failed  = 0;
        errors_before = 0;
        done          = 1'b0;
        hung          = 1'b0;
        test_names = '{"reset", "register readback", "address errors",
                       "frame-synchronous update", "zero box"};
        $readmemh("sim/overlay_vectors.hex", vectors);
        repeat (8) @(posedge pix_clk);
        rst <= 1'b0;
        op_i = 0;
        while (!done && !hung && op_i < MAX_OPS) begin
            base = op_i * N_FIELDS;
            op   = vectors[base];
            case (op)
                OP_WRITE, OP_READ: begin
                    apb_access(op == OP_WRITE, vectors[base+1][7:0], vectors[base+2],
                               vectors[base+3], vectors[base+4][0], ok);
                    if (!ok) begin
                        $display("APB access to 0x%h never saw pready", vectors[base+1][7:0]);
                        hung = 1'b1;
                    end
                end
                OP_FRAME: begin
                    wait_frame(ok);
                    if (!ok) begin
                        $display("no vsync rising edge on o_video within %0d cycles",
                                 FRAME_TIMEOUT);
                        hung = 1'b1;
                    end
                end
                OP_IDLE: repeat (vectors[base+2]) @(posedge pix_clk);
                OP_END_TEST: begin
                    // The error count settles between clock edges
                    @(negedge pix_clk);
                    fails         = checker_errors - errors_before;
                    errors_before = checker_errors;
                    if (fails != 0) tests_failed++;
                    $display("test %0d %s: %0d errors", tests_run,
                             (tests_run < 5) ? test_names[tests_run] : "extra", fails);
                    tests_run++;
                end
                default: done = 1'b1;
            endcase
            op_i++;
        end
        @(negedge pix_clk);
        if (tests_run == 0) $display("no test finished, the vector file gave no tests");
        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, checker_errors);
        if (hung || tests_run == 0 || tests_failed != 0 || checker_errors != 0) begin
            $display("sim failed");
        end else begin
            $display("sim passed");
        end
        $finish;
    end

endmodule : tb_video_overlay

`default_nettype wire

// ==== sim/overlay_vectors.hex ====
// op addr wdata rdata err; op 0 write, 1 read, 2 wait for vsync on o_video,
// 3 idle for wdata cycles, 4 end of test number addr, F end of vectors
1 00 00000000 00000000 0
1 04 00000000 00000000 0
1 08 00000000 00000000 0
1 10 00000000 00000000 0
1 14 00000000 00000000 0
1 18 00000000 00000000 0
2 00 00000000 00000000 0
4 00 00000000 00000000 0
0 00 F004F003 00000000 0
0 04 0009000C 00000000 0
0 08 ABFF0000 00000000 0
0 10 00060008 00000000 0
0 14 000C0014 00000000 0
0 18 1200FF00 00000000 0
1 00 00000000 00040003 0
1 04 00000000 0009000C 0
1 08 00000000 00FF0000 0
1 10 00000000 00060008 0
1 14 00000000 000C0014 0
1 18 00000000 0000FF00 0
4 01 00000000 00000000 0
0 0C 12345678 00000000 1
0 1C FFFFFFFF 00000000 1
0 20 00010001 00000000 1
0 F4 00010001 00000000 1
1 0C 00000000 00000000 1
1 24 00000000 00000000 1
1 00 00000000 00040003 0
1 08 00000000 00FF0000 0
1 18 00000000 0000FF00 0
4 02 00000000 00000000 0
2 00 00000000 00000000 0
3 00 0000012C 00000000 0
0 08 000000FF 00000000 0
1 08 00000000 000000FF 0
2 00 00000000 00000000 0
2 00 00000000 00000000 0
4 03 00000000 00000000 0
0 10 00000000 00000000 0
0 14 00000000 00000000 0
1 10 00000000 00000000 0
2 00 00000000 00000000 0
2 00 00000000 00000000 0
4 04 00000000 00000000 0
F 00 00000000 00000000 0

// ==== verilog.f ====
verilog/video_pkg.sv
verilog/apb_pkg.sv
verilog/video_timing_gen.sv
verilog/box_reg_bank.sv
verilog/draw_window.sv
verilog/video_overlay_top.sv
sim/overlay_checker.sv
sim/tb_video_overlay.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the box overlay testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal --top-module tb_video_overlay -f verilog.f -o tb_video_overlay
./obj_dir/tb_video_overlay > sim.log 2>&1
cat sim.log

if grep -q "sim failed" sim.log; then
    exit 1
fi
exit 0
